// ==== Bender.yml ====
package:
  name: zports

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/zbus_pkg.sv
      - source/sysreg_pkg.sv
      - source/port_decode.sv
      - source/sys_config_regs.sv
      - source/port_read_mux.sv
      - source/zports_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - tb/tb_zports.sv

// ==== all.f ====
+incdir+source
source/zbus_pkg.sv
source/sysreg_pkg.sv
source/port_decode.sv
source/sys_config_regs.sv
source/port_read_mux.sv
source/zports_top.sv
tb/tb_zports.sv

// ==== source/port_decode.sv ====
// low address decode into port hits, register strobes and sd start
`timescale 1ns/1ps

`include "zports_settings.svh"

module port_decode
  import zbus_pkg::*;
(
  input  z80_bus_t  bus,
  output port_sel_t sel,
  output logic      porthit,
  output logic      external_port,
  output logic      dataout,
  output logic      sd_start
);

  port_addr_t loa;
  logic       hit_any_mode;
  logic       hit_no_dos;
  logic       xt_hit;
  logic       sddat_hit;

  assign loa = bus.a[7:0];

  assign xt_hit    = (loa == `ZP_PORTXT);
  assign sddat_hit = (loa == `ZP_SDDAT);

  // ports owned in any mode
  always_comb
  begin
    hit_any_mode = (loa == `ZP_PORTFE) ||
                   xt_hit ||
                   (loa == `ZP_PORTFD) ||
                   sddat_hit ||
                   (loa == `ZP_SDCFG) ||
                   (loa == `ZP_KMOUSE) ||
                   (loa == `ZP_COMPORT);
  end

  // F7 and joystick collide with trdos ports
  assign hit_no_dos = !bus.dos && ((loa == `ZP_PORTF7) || (loa == `ZP_KJOY));

  assign porthit = hit_any_mode || hit_no_dos;

  // AY sits on FFFD/BFFD
  assign external_port = (loa == `ZP_PORTFD) && bus.a[15];

  assign dataout = porthit && bus.iord && !external_port;

  always_comb
  begin
    // loader writes carry the index in the low byte
    if (bus.regs_we)
      sel.xt_index = bus.a[7:0];
    else
      sel.xt_index = bus.a[15:8];

    sel.xt_wr     = (xt_hit && bus.iowr_s) || bus.regs_we;
    sel.xt_rd     = xt_hit && bus.iord_s;
    sel.fd_wr     = !bus.a[15] && (loa == `ZP_PORTFD) && bus.iowr_s;
    sel.sdcfg_wr  = (loa == `ZP_SDCFG) && bus.iowr_s;
    sel.sd_access = sddat_hit && (bus.iowr_s || bus.iord_s);
  end

  // spi transfer starts on either direction
  assign sd_start = sel.sd_access;

  // a cpu strobe hits one port only, only the loader path may overlap 7FFD
  always_comb
  begin
    a_xt_fd_excl: assert final (bus.regs_we || !(sel.xt_wr && sel.fd_wr))
      else $error("extended register write and 7FFD write in the same cycle");
  end

endmodule

// ==== source/port_read_mux.sv ====
// read data selection for owned ports, power-up status flag, spi write data
`timescale 1ns/1ps

`include "zports_settings.svh"

module port_read_mux
  import zbus_pkg::*;
  import sysreg_pkg::*;
(
  input  logic       clk,
  input  z80_bus_t   bus,
  input  port_sel_t  sel,
  input  sys_cfg_t   cfg,
  input  logic [4:0] keys_in,
  input  logic       tape_read,
  input  zdata_t     kj_in,
  input  zdata_t     mus_in,
  input  zdata_t     sd_dataout,
  output zdata_t     dout,
  output zdata_t     sd_datain
);

  localparam port_addr_t IDX_XSTAT = `ZP_XT_XSTAT;
  localparam port_addr_t IDX_PAGE2 = `ZP_XT_RAMPAGE + 8'd2;
  localparam port_addr_t IDX_PAGE3 = `ZP_XT_RAMPAGE + 8'd3;

  // power-up flag, set by fpga configuration and not by rst
  logic pwr_up = 1'b1;

  always_ff @(posedge clk)
  begin
    if (sel.xt_rd && (sel.xt_index == IDX_XSTAT))
      pwr_up <= 1'b0;
  end

  always_comb
  begin
    case (bus.a[7:0])
      `ZP_PORTFE: dout = {1'b1, tape_read, 1'b1, keys_in};
      `ZP_PORTXT:
      begin
        case (sel.xt_index)
          IDX_XSTAT:            dout = {1'b0, pwr_up, 1'b0, 2'b00, `ZP_VDAC_VER};
          IDX_PAGE2, IDX_PAGE3: dout = cfg.xt_page[sel.xt_index[1:0]];
          default:              dout = 8'hFF;
        endcase
      end
      `ZP_KJOY:   dout = kj_in;
      `ZP_KMOUSE: dout = mus_in;
      `ZP_SDCFG:  dout = 8'h00;  // card present and not write protected
      `ZP_SDDAT:  dout = sd_dataout;
      default:    dout = 8'hFF;
    endcase
  end

  // idle spi shifts out ones
  assign sd_datain = bus.wr ? bus.din : 8'hFF;

endmodule

// ==== source/sys_config_regs.sv ====
// configuration register file, 7FFD paging with lock modes, sd chip selects
`timescale 1ns/1ps

`include "zports_settings.svh"

module sys_config_regs
  import zbus_pkg::*;
  import sysreg_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  z80_bus_t  bus,
  input  port_sel_t sel,
  output sys_cfg_t  cfg
);

  localparam port_addr_t IDX_RAMPAGE   = `ZP_XT_RAMPAGE;
  localparam port_addr_t IDX_FMADDR    = `ZP_XT_FMADDR;
  localparam port_addr_t IDX_SYSCONF   = `ZP_XT_SYSCONF;
  localparam port_addr_t IDX_MEMCONF   = `ZP_XT_MEMCONF;
  localparam port_addr_t IDX_INTMASK   = `ZP_XT_INTMASK;
  localparam port_addr_t IDX_CACHECONF = `ZP_XT_CACHECONF;

  xt_page_t   pages;
  logic [7:0] sysconf;
  logic [7:0] memconf;
  cache_cfg_t cacheconf;
  fm_addr_t   fmaddr;
  logic [7:0] intmask;
  spi_cs_t    spi_cs_n;

  logic       lock48;      // 48K lock, set through 7FFD bit 5
  logic       m1_lock128;  // lock sampled on the last opcode fetch
  logic       lock128;
  lock_mode_t lock_mode;
  logic       p7ffd_wr;
  page_t      fd_page;

  assign lock_mode = memconf[7:6];

  always_comb
  begin
    case (lock_mode)
      LOCK_MODE_512: lock128 = 1'b0;
      LOCK_MODE_M1:  lock128 = m1_lock128;
      default:       lock128 = memconf[6];
    endcase
  end

  // new page 3 value for a 7FFD write
  always_comb
  begin
    if (lock_mode == LOCK_MODE_512)
      fd_page = {2'b00, bus.din[5], bus.din[7:6], bus.din[2:0]};
    else
      fd_page = {3'b000, (lock128 ? 2'b00 : bus.din[7:6]), bus.din[2:0]};
  end

  assign p7ffd_wr = sel.fd_wr && !lock48;

  always_ff @(posedge clk)
  begin
    if (bus.opfetch)
      m1_lock128 <= !(bus.din[7] ^ bus.din[6]);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pages[0]  <= `ZP_RST_PAGE0;
      pages[1]  <= `ZP_RST_PAGE1;
      pages[2]  <= `ZP_RST_PAGE2;
      pages[3]  <= `ZP_RST_PAGE3;
      sysconf   <= 8'h00;  // 3.5 MHz
      memconf   <= `ZP_RST_MEMCONF;
      cacheconf <= 4'h0;
      intmask   <= `ZP_RST_INTMASK;
      fmaddr[4] <= 1'b0;   // fm off, low bits don't matter
    end
    else if (p7ffd_wr)
    begin
      memconf[0] <= bus.din[4];  // rom select
      pages[3]   <= fd_page;
    end
    else if (sel.xt_wr)
    begin
      if (sel.xt_index[7:2] == IDX_RAMPAGE[7:2])
        pages[sel.xt_index[1:0]] <= bus.din;
      if (sel.xt_index == IDX_FMADDR)
        fmaddr <= bus.din[4:0];
      if (sel.xt_index == IDX_SYSCONF)
      begin
        sysconf   <= bus.din;
        cacheconf <= {4{bus.din[2]}};  // cache bit applies to all windows
      end
      if (sel.xt_index == IDX_CACHECONF)
        cacheconf <= bus.din[3:0];
      if (sel.xt_index == IDX_MEMCONF)
        memconf <= bus.din;
      if (sel.xt_index == IDX_INTMASK)
        intmask <= bus.din;
    end
  end

  // mode 3 leaves the 48K lock alone
  always_ff @(posedge clk)
  begin
    if (rst)
      lock48 <= 1'b0;
    else if (p7ffd_wr && (lock_mode != LOCK_MODE_512))
      lock48 <= bus.din[5];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      spi_cs_n <= 3'b111;
    else if (sel.sdcfg_wr)
      spi_cs_n <= {~bus.din[3:2], bus.din[1]};
  end

  always_comb
  begin
    cfg.xt_page   = pages;
    cfg.sysconf   = sysconf;
    cfg.memconf   = memconf;
    cfg.cacheconf = cacheconf;
    cfg.fmaddr    = fmaddr;
    cfg.intmask   = intmask;
    cfg.spi_cs_n  = spi_cs_n;
  end

  // all cards deselected once reset is seen
  a_cs_after_rst: assert property (@(posedge clk) rst |=> (cfg.spi_cs_n == 3'b111))
    else $error("spi selects not released after reset");

endmodule

// ==== source/sysreg_pkg.sv ====
// configuration register types and the packed configuration struct
package sysreg_pkg;

  // one 16K ram page number
  typedef logic [7:0] page_t;

  // four window pages, page 0 in the low byte
  typedef page_t [3:0] xt_page_t;

  // active-low selects, bit 0 sd, bit 1 ft, bit 2 sd2
  typedef logic [2:0] spi_cs_t;

  // paging lock mode, memconf[7:6]
  typedef logic [1:0] lock_mode_t;

  // cache enable per 16K window
  typedef logic [3:0] cache_cfg_t;

  // FM address bits
  typedef logic [4:0] fm_addr_t;

  // everything the rest of the machine sees, 68 bits
  typedef struct packed {
    xt_page_t   xt_page;
    logic [7:0] sysconf;    // cpu clock and cache mode
    logic [7:0] memconf;    // rom mapping, lock mode
    cache_cfg_t cacheconf;
    fm_addr_t   fmaddr;
    logic [7:0] intmask;
    spi_cs_t    spi_cs_n;
  } sys_cfg_t;

  // lock mode codes
  localparam lock_mode_t LOCK_MODE_M1  = 2'b10;  // lock taken from last opfetch
  localparam lock_mode_t LOCK_MODE_512 = 2'b11;  // no 128K lock, extra page bit

endpackage

// ==== source/zbus_pkg.sv ====
// Z80 bus types and the decoded port selection struct
package zbus_pkg;

  // one byte of the I/O address
  typedef logic [7:0] port_addr_t;

  // one byte on the data bus
  typedef logic [7:0] zdata_t;

  // full address
  typedef logic [15:0] zaddr_t;

  // bus as seen by the port block, strobes are one clk wide
  typedef struct packed {
    zdata_t din;      // cpu write data
    zaddr_t a;
    logic   wr;       // level, write cycle in progress
    logic   iord;     // level, io read in progress
    logic   iord_s;   // io read strobe
    logic   iowr_s;   // io write strobe
    logic   opfetch;  // m1 data valid
    logic   regs_we;  // register write from the loader side, index in a[7:0]
    logic   dos;      // trdos rom active
  } z80_bus_t;

  // decode result, 13 bits
  typedef struct packed {
    port_addr_t xt_index;  // #nnAF register index
    logic       xt_wr;     // write to an extended register
    logic       xt_rd;     // read strobe on #AF
    logic       fd_wr;     // 7FFD write, lock48 not yet applied
    logic       sdcfg_wr;  // write to #77
    logic       sd_access; // any strobe on #57
  } port_sel_t;

endpackage

// ==== source/zports_settings.svh ====
// port codes, extended register indices and reset values of the I/O port block
`ifndef ZPORTS_SETTINGS_SVH
`define ZPORTS_SETTINGS_SVH

// low address byte of the ports
`define ZP_PORTFE        8'hFE  // keyboard, tape
`define ZP_PORTFD        8'hFD  // 7FFD paging, AY when a15 set
`define ZP_PORTXT        8'hAF  // extended config, index in a[15:8]
`define ZP_PORTF7        8'hF7
`define ZP_KJOY          8'h1F  // kempston joystick
`define ZP_KMOUSE        8'hDF  // kempston mouse
`define ZP_SDCFG         8'h77  // sd chip selects
`define ZP_SDDAT         8'h57  // spi data
`define ZP_COMPORT       8'hEF  // F8EF..FFEF rs232
`define ZP_VGSYS         8'hFF  // floppy system port, now external

// #nnAF register indices
`define ZP_XT_XSTAT      8'h00  // status, read only
`define ZP_XT_RAMPAGE    8'h10  // covers #10..#13
`define ZP_XT_FMADDR     8'h15
`define ZP_XT_SYSCONF    8'h20
`define ZP_XT_MEMCONF    8'h21
`define ZP_XT_INTMASK    8'h2A
`define ZP_XT_CACHECONF  8'h2B

// reset values
`define ZP_RST_MEMCONF   8'h04  // rom mapping off
`define ZP_RST_INTMASK   8'h01  // frame int only
`define ZP_RST_PAGE0     8'h00
`define ZP_RST_PAGE1     8'h05
`define ZP_RST_PAGE2     8'h02
`define ZP_RST_PAGE3     8'h00

// version field of the status byte
`define ZP_VDAC_VER      3'h7

`endif

// ==== source/zports_top.sv ====
// top of the I/O port block, decode feeding the register file and read mux
`timescale 1ns/1ps

module zports_top
  import zbus_pkg::*;
  import sysreg_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  z80_bus_t   bus,
  input  logic [4:0] keys_in,
  input  logic       tape_read,
  input  zdata_t     kj_in,
  input  zdata_t     mus_in,
  input  zdata_t     sd_dataout,
  output zdata_t     dout,
  output logic       dataout,
  output logic       porthit,
  output logic       external_port,
  output sys_cfg_t   cfg,
  output logic       sd_start,
  output zdata_t     sd_datain
);

  port_sel_t sel;

  port_decode i_decode (
    .bus           (bus),
    .sel           (sel),
    .porthit       (porthit),
    .external_port (external_port),
    .dataout       (dataout),
    .sd_start      (sd_start)
  );

  sys_config_regs i_regs (
    .clk (clk),
    .rst (rst),
    .bus (bus),
    .sel (sel),
    .cfg (cfg)
  );

  port_read_mux i_rdmux (
    .clk        (clk),
    .bus        (bus),
    .sel        (sel),
    .cfg        (cfg),
    .keys_in    (keys_in),
    .tape_read  (tape_read),
    .kj_in      (kj_in),
    .mus_in     (mus_in),
    .sd_dataout (sd_dataout),
    .dout       (dout),
    .sd_datain  (sd_datain)
  );

endmodule

// ==== tb/tb_zports.sv ====
// testbench of the I/O port block, shadow config model, LFSR stimulus, assertion checks
`timescale 1ns/1ps

`include "zports_settings.svh"

module tb_zports
  import zbus_pkg::*;
  import sysreg_pkg::*;
;

  localparam int RST_CYCLES  = 10;
  localparam int N_XT        = 48;
  localparam int N_FD        = 6;   // open writes per lock mode
  localparam int N_RD        = 40;
  localparam int N_DEC       = 64;
  localparam int N_SD        = 16;
  localparam int MODE_CYCLES = 2 + 4 * N_FD + 6 + RST_CYCLES + 1;
  localparam int STIM_CYCLES = RST_CYCLES + 2 + 2 * N_XT + 4 * MODE_CYCLES + 2 * (N_RD + 2) +
                               N_DEC + 1 + 4 * N_SD + 3;
  localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

  logic       clk;
  logic       rst;
  z80_bus_t   bus;
  logic [4:0] keys_in;
  logic       tape_read;
  zdata_t     kj_in;
  zdata_t     mus_in;
  zdata_t     sd_dataout;
  zdata_t     dout;
  zdata_t     sd_datain;
  logic       dataout;
  logic       porthit;
  logic       external_port;
  logic       sd_start;
  sys_cfg_t   cfg;

  sys_cfg_t    exp_cfg;      // shadow of the register file
  logic        exp_lock48;
  logic        exp_m1;
  logic        exp_pwr = 1'b1;
  logic        fm_known = 1'b0;  // fmaddr[3:0] has no reset value
  zdata_t      exp_dout;
  logic        exp_porthit;
  logic        cfg_ok;
  logic        reset_ok;
  port_addr_t  lo;
  port_addr_t  xt_idx;
  logic        fd_strobe;
  logic        xt_strobe;
  logic        sdcfg_strobe;
  logic        stat_rd;
  logic        wr_strobe;
  logic [31:0] lfsr = 32'h901a_db3c;
  int          err_count = 0;
  int          wr_count = 0;
  int          rd_count = 0;
  int          cycles = 0;

  zports_top i_dut (
    .clk (clk), .rst (rst), .bus (bus), .keys_in (keys_in), .tape_read (tape_read),
    .kj_in (kj_in), .mus_in (mus_in), .sd_dataout (sd_dataout), .dout (dout),
    .dataout (dataout), .porthit (porthit), .external_port (external_port), .cfg (cfg),
    .sd_start (sd_start), .sd_datain (sd_datain)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // fibonacci lfsr x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // page 3 after a 7FFD write
  function automatic page_t fd_page3(input logic [1:0] mode, input logic m1,
                                     input logic mem6, input zdata_t d);
    logic lock128;
    if (mode == 2'b11)
      return {2'b00, d[5], d[7:6], d[2:0]};
    lock128 = (mode == 2'b10) ? m1 : mem6;
    if (lock128)
      return {5'b00000, d[2:0]};
    return {3'b000, d[7:6], d[2:0]};
  endfunction

  task automatic flag_error(input string msg);
    err_count++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  assign lo           = bus.a[7:0];
  assign xt_idx       = bus.regs_we ? bus.a[7:0] : bus.a[15:8];
  assign fd_strobe    = bus.iowr_s && (lo == `ZP_PORTFD) && !bus.a[15];
  assign xt_strobe    = (bus.iowr_s && (lo == `ZP_PORTXT)) || bus.regs_we;
  assign sdcfg_strobe = bus.iowr_s && (lo == `ZP_SDCFG);
  assign stat_rd      = bus.iord_s && (lo == `ZP_PORTXT) && (xt_idx == `ZP_XT_XSTAT);
  assign wr_strobe    = bus.iowr_s || bus.regs_we;

  always @(posedge clk)
  begin
    if (bus.opfetch)
      exp_m1 <= ~(bus.din[7] ^ bus.din[6]);
    if (stat_rd)
      exp_pwr <= 1'b0;  // only configuration sets it
    if (rst)
    begin
      exp_cfg.xt_page   <= 32'h0002_0500;
      exp_cfg.sysconf   <= 8'h00;
      exp_cfg.memconf   <= 8'h04;
      exp_cfg.cacheconf <= 4'h0;
      exp_cfg.intmask   <= 8'h01;
      exp_cfg.fmaddr[4] <= 1'b0;
      exp_cfg.spi_cs_n  <= 3'b111;
      exp_lock48        <= 1'b0;
    end
    else
    begin
      if (fd_strobe && !exp_lock48)
      begin
        exp_cfg.memconf[0] <= bus.din[4];
        exp_cfg.xt_page[3] <= fd_page3(exp_cfg.memconf[7:6], exp_m1, exp_cfg.memconf[6],
                                       bus.din);
        if (exp_cfg.memconf[7:6] != 2'b11)
          exp_lock48 <= bus.din[5];
      end
      else if (xt_strobe)
      begin
        case (xt_idx)
          `ZP_XT_RAMPAGE, `ZP_XT_RAMPAGE + 8'd1, `ZP_XT_RAMPAGE + 8'd2, `ZP_XT_RAMPAGE + 8'd3:
            exp_cfg.xt_page[xt_idx[1:0]] <= bus.din;
          `ZP_XT_FMADDR:
          begin
            exp_cfg.fmaddr <= bus.din[4:0];
            fm_known       <= 1'b1;
          end
          `ZP_XT_SYSCONF:
          begin
            exp_cfg.sysconf   <= bus.din;
            exp_cfg.cacheconf <= {4{bus.din[2]}};
          end
          `ZP_XT_MEMCONF:   exp_cfg.memconf   <= bus.din;
          `ZP_XT_INTMASK:   exp_cfg.intmask   <= bus.din;
          `ZP_XT_CACHECONF: exp_cfg.cacheconf <= bus.din[3:0];
          default: ;
        endcase
      end
      if (sdcfg_strobe)
        exp_cfg.spi_cs_n <= {~bus.din[3], ~bus.din[2], bus.din[1]};
    end
  end

  always_comb
  begin
    cfg_ok = (cfg.xt_page === exp_cfg.xt_page) && (cfg.sysconf === exp_cfg.sysconf) &&
             (cfg.memconf === exp_cfg.memconf) && (cfg.cacheconf === exp_cfg.cacheconf) &&
             (cfg.intmask === exp_cfg.intmask) && (cfg.spi_cs_n === exp_cfg.spi_cs_n) &&
             (cfg.fmaddr[4] === exp_cfg.fmaddr[4]) &&
             (!fm_known || (cfg.fmaddr === exp_cfg.fmaddr));
    reset_ok = (cfg.xt_page == 32'h0002_0500) && (cfg.sysconf == 8'h00) &&
               (cfg.memconf == 8'h04) && (cfg.cacheconf == 4'h0) && (cfg.intmask == 8'h01) &&
               (cfg.fmaddr[4] == 1'b0) && (cfg.spi_cs_n == 3'b111);
    exp_porthit = (lo inside {8'hFE, 8'hAF, 8'hFD, 8'h57, 8'h77, 8'hDF, 8'hEF}) ||
                  (!bus.dos && (lo inside {8'hF7, 8'h1F}));
  end

  always_comb
  begin
    case (lo)
      `ZP_PORTFE: exp_dout = {1'b1, tape_read, 1'b1, keys_in};
      `ZP_PORTXT:
      begin
        if (xt_idx == `ZP_XT_XSTAT)
          exp_dout = {1'b0, exp_pwr, 3'b000, `ZP_VDAC_VER};
        else if (xt_idx == `ZP_XT_RAMPAGE + 8'd2)
          exp_dout = exp_cfg.xt_page[2];
        else if (xt_idx == `ZP_XT_RAMPAGE + 8'd3)
          exp_dout = exp_cfg.xt_page[3];
        else
          exp_dout = 8'hFF;
      end
      `ZP_KJOY:   exp_dout = kj_in;
      `ZP_KMOUSE: exp_dout = mus_in;
      `ZP_SDCFG:  exp_dout = 8'h00;
      `ZP_SDDAT:  exp_dout = sd_dataout;
      default:    exp_dout = 8'hFF;
    endcase
  end

  a_reset_values: assert property (@(posedge clk) rst |=> reset_ok)
    else flag_error("config differs from the reset values");
  a_cfg_write: assert property (@(posedge clk) wr_strobe |=> cfg_ok)
    else flag_error("config differs from the shadow after a write strobe");
  a_read_data: assert property (@(posedge clk) dout == exp_dout)
    else flag_error("read data mismatch");
  a_decode: assert property (@(posedge clk) (porthit == exp_porthit) &&
      (external_port == ((lo == `ZP_PORTFD) && bus.a[15])) &&
      (dataout == (exp_porthit && bus.iord && !((lo == `ZP_PORTFD) && bus.a[15]))))
    else flag_error("port decode mismatch");
  a_sd_bus: assert property (@(posedge clk)
      (sd_start == ((lo == `ZP_SDDAT) && (bus.iowr_s || bus.iord_s))) &&
      (sd_datain == (bus.wr ? bus.din : 8'hFF)))
    else flag_error("sd start or write data mismatch");

  task automatic apply_reset;
    @(negedge clk);
    rst = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic write_port(input logic [15:0] addr, input zdata_t data);
    @(negedge clk);
    bus.a      = addr;
    bus.din    = data;
    bus.wr     = 1'b1;
    bus.iowr_s = 1'b1;
    @(negedge clk);
    bus.iowr_s = 1'b0;
    bus.wr     = 1'b0;
    wr_count++;
  endtask

  // loader path carries the index in the low byte
  task automatic loader_write(input port_addr_t idx, input zdata_t data);
    zdata_t hi;
    hi = take_bits(8);
    @(negedge clk);
    bus.a       = {hi, idx};
    bus.din     = data;
    bus.regs_we = 1'b1;
    @(negedge clk);
    bus.regs_we = 1'b0;
    wr_count++;
  endtask

  task automatic opfetch_cycle(input zdata_t data);
    @(negedge clk);
    bus.din     = data;
    bus.opfetch = 1'b1;
    @(negedge clk);
    bus.opfetch = 1'b0;
  endtask

  task automatic read_port(input logic [15:0] addr);
    @(negedge clk);
    bus.a      = addr;
    bus.iord   = 1'b1;
    bus.iord_s = 1'b1;
    keys_in    = take_bits(5);
    tape_read  = take_bits(1);
    kj_in      = take_bits(8);
    mus_in     = take_bits(8);
    sd_dataout = take_bits(8);
    @(negedge clk);
    bus.iord   = 1'b0;
    bus.iord_s = 1'b0;
    rd_count++;
  endtask

  task automatic xt_write_burst;
    port_addr_t idx_list [9] = '{8'h10, 8'h11, 8'h12, 8'h13, `ZP_XT_FMADDR, `ZP_XT_SYSCONF,
                                 `ZP_XT_MEMCONF, `ZP_XT_INTMASK, `ZP_XT_CACHECONF};
    port_addr_t idx;
    zdata_t     data;
    for (int i = 0; i < N_XT; i++)
    begin
      idx  = idx_list[take_bits(4) % 9];
      data = take_bits(8);
      if (take_bits(1))
        loader_write(idx, data);
      else
        write_port({idx, `ZP_PORTXT}, data);
    end
  endtask

  task automatic lock_mode_sweep;
    zdata_t data;
    for (int mode = 0; mode < 4; mode++)
    begin
      data      = take_bits(8);
      data[7:6] = mode[1:0];
      loader_write(`ZP_XT_MEMCONF, data);
      for (int i = 0; i < N_FD; i++)
      begin
        opfetch_cycle(take_bits(8));
        write_port(16'h7FFD, take_bits(8) & 8'hDF);  // bit 5 clear keeps the port open
      end
      write_port(16'h7FFD, take_bits(8) | 8'h20);
      write_port(16'h7FFD, take_bits(8));  // ignored unless mode 3
      write_port(16'h3FFD, take_bits(8));
      apply_reset;
    end
  endtask

  task automatic port_read_sweep;
    logic [15:0] addr_list [8] = '{16'h00FE, 16'h001F, 16'h00DF, 16'h0077, 16'h0057,
                                   16'h00AF, 16'h12AF, 16'h13AF};
    logic [15:0] addr;
    read_port(16'h00AF);  // flag still set here
    read_port(16'h00AF);
    for (int i = 0; i < N_RD; i++)
    begin
      if (take_bits(2) == 0)
        addr = take_bits(16);
      else
        addr = addr_list[take_bits(3)];
      if (addr[7:0] != `ZP_PORTXT)
        addr[15:8] = take_bits(8);
      read_port(addr);
    end
  endtask

  task automatic decode_sweep;
    port_addr_t port_list [10] = '{8'hFE, 8'hAF, 8'hFD, 8'h57, 8'h77, 8'hDF, 8'hEF, 8'hF7,
                                   8'h1F, 8'hFF};
    for (int i = 0; i < N_DEC; i++)
    begin
      @(negedge clk);
      bus.dos  = take_bits(1);
      bus.iord = take_bits(1);
      bus.wr   = take_bits(1);
      bus.din  = take_bits(8);
      bus.a    = take_bits(16);
      if (take_bits(1))
        bus.a[7:0] = port_list[take_bits(4) % 10];
    end
    @(negedge clk);
    bus.dos  = 1'b0;
    bus.iord = 1'b0;
    bus.wr   = 1'b0;
  endtask

  task automatic sd_transfers;
    zdata_t hi;
    for (int i = 0; i < N_SD; i++)
    begin
      hi = take_bits(8);
      write_port({hi, `ZP_SDCFG}, take_bits(8));
      if (take_bits(1))
        write_port(16'h0057, take_bits(8));
      else
        read_port(16'h0057);
    end
  endtask

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  initial
  begin
    rst        = 1'b1;
    bus        = '0;
    keys_in    = '0;
    tape_read  = 1'b0;
    kj_in      = '0;
    mus_in     = '0;
    sd_dataout = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    write_port({`ZP_XT_FMADDR, `ZP_PORTXT}, take_bits(8));
    xt_write_burst();
    lock_mode_sweep();
    port_read_sweep();
    decode_sweep();
    sd_transfers();
    repeat (3) @(negedge clk);
    $display("writes %0d, reads %0d, errors %0d", wr_count, rd_count, err_count);
    if (err_count == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule
